// File: rtl/db_pkg.sv
// shared widths and helpers for the deblocking / SAO slice
// holds the tc table, the pixel clip and the SAO word layout
// every design file pulls this in by a wildcard import
package db_pkg;

    localparam int PIX_W      = 8;        // one pixel
    localparam int PIX4_W     = 4*PIX_W;  // p0/q0 in bits [7:0]
    localparam int MV_W       = 10;       // one mv component, quarter pel
    localparam int QP_W       = 6;
    localparam int LCU_X_W    = 4;        // 16 lcu columns in the top store
    localparam int BS_W       = 2;
    localparam int TC_W       = 5;        // tc value, max 24
    localparam int TC_IDX_MAX = 53;
    localparam int MV_THRESH  = 4;        // one integer pel
    localparam int SAO_W      = 19;

    localparam logic [1:0] SAO_OFF  = 2'd0;
    localparam logic [1:0] SAO_BAND = 2'd1;
    localparam logic [1:0] SAO_EDGE = 2'd2;  // 3 is reserved, acts as off

    // tc for index 18..53, below 18 tc is zero
    localparam logic [TC_W-1:0] TC_TAB [36] = '{
        5'd1,  5'd1,  5'd1,  5'd1,  5'd1,  5'd1,  5'd1,  5'd1,  5'd1,
        5'd2,  5'd2,  5'd2,  5'd2,  5'd3,  5'd3,  5'd3,  5'd3,
        5'd4,  5'd4,  5'd4,  5'd5,  5'd5,  5'd6,  5'd6,
        5'd7,  5'd8,  5'd9,  5'd10, 5'd11, 5'd13, 5'd14, 5'd16,
        5'd18, 5'd20, 5'd22, 5'd24
    };

    function automatic logic [TC_W-1:0] tc_lookup(input logic [5:0] idx);
        logic [5:0] k;
        k = (idx > 6'(TC_IDX_MAX)) ? 6'(TC_IDX_MAX - 18) : idx - 6'd18;
        return (idx < 6'd18) ? '0 : TC_TAB[k];
    endfunction

    // saturate a widened signed sum back to 0..255
    function automatic logic [PIX_W-1:0] clip_pix(input logic signed [9:0] v);
        if (v < 0)
            return '0;
        if (v > 10'sd255)
            return 8'hff;
        return v[PIX_W-1:0];
    endfunction

    // one SAO word, read as band params or as edge params
    typedef union packed {
        struct packed {
            logic [1:0]      typ;
            logic [4:0]      band_pos;
            logic [3:0][2:0] off;      // off[k] is signed, for band_pos+k
        } bo;
        struct packed {
            logic [1:0]      typ;
            logic [3:0][3:0] mag;      // mag[c-1] for category c
            logic            rsvd;
        } eo;
    } sao_word_u;

endpackage

// File: rtl/db_if.sv
// stage-to-stage bundles of the filter slice
// db_seg_if: bs calc -> luma filter, db_pix_if: luma filter -> SAO
// valid is a single-cycle strobe, the rest is payload under valid
`timescale 1ns/1ps

interface db_seg_if;
    import db_pkg::*;

    logic              valid;
    logic [BS_W-1:0]   bs;
    logic [TC_W-1:0]   tc;     // tc value, already looked up
    logic [PIX4_W-1:0] pix_p;
    logic [PIX4_W-1:0] pix_q;

    modport src (output valid, bs, tc, pix_p, pix_q);
    modport dst (input  valid, bs, tc, pix_p, pix_q);
endinterface

interface db_pix_if;
    import db_pkg::*;

    logic              valid;
    logic [BS_W-1:0]   bs;     // rides along for the top-level bs output
    logic [PIX4_W-1:0] pix_p;  // p0/q0 already filtered
    logic [PIX4_W-1:0] pix_q;
    sao_word_u         sao_p;
    sao_word_u         sao_q;

    modport src (output valid, bs, pix_p, pix_q, sao_p, sao_q);
    modport dst (input  valid, bs, pix_p, pix_q, sao_p, sao_q);
endinterface

// File: rtl/db_bs_calc.sv
// boundary strength and tc for one edge segment
// one register stage, runs beside db_sao_select
`timescale 1ns/1ps

module db_bs_calc (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        seg_valid_i,
    input  logic                        intra_i,
    input  logic                        tu_edge_i,
    input  logic                        pu_edge_i,
    input  logic                        cbf_p_i,
    input  logic                        cbf_q_i,
    input  logic [2*db_pkg::MV_W-1:0]   mv_p_i,     // y high, x low
    input  logic [2*db_pkg::MV_W-1:0]   mv_q_i,
    input  logic [db_pkg::QP_W-1:0]     qp_i,
    input  logic [db_pkg::PIX4_W-1:0]   pix_p_i,
    input  logic [db_pkg::PIX4_W-1:0]   pix_q_i,
    db_seg_if.src                       seg
);
    import db_pkg::*;

    logic signed [MV_W:0] dx_w, dy_w;   // one bit wider, no overflow
    logic [MV_W:0]        ax_w, ay_w;
    logic                 mv_big_w;
    logic [BS_W-1:0]      bs_w;
    logic [QP_W:0]        idx_w;        // qp + 2 can reach 65

    // mv distance per component
    assign dx_w = $signed({mv_p_i[MV_W-1], mv_p_i[MV_W-1:0]})
                - $signed({mv_q_i[MV_W-1], mv_q_i[MV_W-1:0]});
    assign dy_w = $signed({mv_p_i[2*MV_W-1], mv_p_i[2*MV_W-1:MV_W]})
                - $signed({mv_q_i[2*MV_W-1], mv_q_i[2*MV_W-1:MV_W]});
    assign ax_w = dx_w[MV_W] ? -dx_w : dx_w;
    assign ay_w = dy_w[MV_W] ? -dy_w : dy_w;
    assign mv_big_w = (ax_w >= (MV_W+1)'(MV_THRESH)) || (ay_w >= (MV_W+1)'(MV_THRESH));

    always_comb begin
        if (intra_i && (tu_edge_i || pu_edge_i))
            bs_w = 2'd2;                        // intra edge
        else if (tu_edge_i && (cbf_p_i || cbf_q_i))
            bs_w = 2'd1;                        // coded residual
        else if (pu_edge_i && mv_big_w)
            bs_w = 2'd1;                        // motion discontinuity
        else
            bs_w = 2'd0;
        idx_w = {1'b0, qp_i} + ((bs_w == 2'd2) ? 7'd2 : 7'd0);
        if (idx_w > 7'(TC_IDX_MAX))
            idx_w = 7'(TC_IDX_MAX);             // clamp table index
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            seg.valid <= 1'b0;
        else
            seg.valid <= seg_valid_i;
    end

    always_ff @(posedge clk) begin
        if (seg_valid_i) begin
            seg.bs    <= bs_w;
            seg.tc    <= tc_lookup(idx_w[5:0]);
            seg.pix_p <= pix_p_i;
            seg.pix_q <= pix_q_i;
        end
    end

endmodule

// File: rtl/db_sao_select.sv
// SAO parameter store and neighbour pick
// current, left and a 16-entry top row, refreshed on each lcu start
// q side always gets current, p side may reach across the lcu edge
`timescale 1ns/1ps

module db_sao_select (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         lcu_start_i,
    input  logic [db_pkg::LCU_X_W-1:0]   lcu_x_i,
    input  db_pkg::sao_word_u            lcu_sao_i,
    input  logic                         seg_valid_i,
    input  logic                         seg_ver_i,      // 1: vertical edge
    input  logic                         seg_lcu_edge_i,
    output db_pkg::sao_word_u            sao_p_o,
    output db_pkg::sao_word_u            sao_q_o
);
    import db_pkg::*;

    localparam int TOP_N = 1 << LCU_X_W;

    sao_word_u cur_r;
    sao_word_u left_r;
    sao_word_u top_r;
    sao_word_u top_mem [TOP_N];   // one word per lcu column
    sao_word_u sel_p_w;

    // ******************************************************************
    // lcu start bookkeeping
    // ******************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_r  <= '0;                       // type off
            left_r <= '0;
            top_r  <= '0;
            for (int i = 0; i < TOP_N; i++) begin
                top_mem[i] <= '0;               // first row has no top
            end
        end else if (lcu_start_i) begin
            left_r           <= cur_r;
            cur_r            <= lcu_sao_i;
            top_r            <= top_mem[lcu_x_i]; // old value, one row up
            top_mem[lcu_x_i] <= lcu_sao_i;
        end
    end

    // ******************************************************************
    // per-segment pick
    // ******************************************************************
    always_comb begin
        if (!seg_lcu_edge_i)
            sel_p_w = cur_r;                    // inside the lcu
        else if (seg_ver_i)
            sel_p_w = left_r;
        else
            sel_p_w = top_r;
    end

    always_ff @(posedge clk) begin
        if (seg_valid_i) begin
            sao_p_o <= sel_p_w;
            sao_q_o <= cur_r;
        end
    end

endmodule

// File: rtl/db_luma_filter.sv
// normal luma deblocking, p0 and q0 only
// delta from p1 p0 q0 q1, skipped when |delta| >= 10*tc or bs is 0
// one register stage, SAO words passed along untouched
`timescale 1ns/1ps

module db_luma_filter (
    input  logic              clk,
    input  logic              rst_n,
    db_seg_if.dst             seg,
    input  db_pkg::sao_word_u sao_p_i,
    input  db_pkg::sao_word_u sao_q_i,
    db_pix_if.src             pix
);
    import db_pkg::*;

    logic [PIX_W-1:0]  p0_w, p1_w, q0_w, q1_w;
    logic signed [12:0] delta_w;        // wide enough for 9*255 + 3*255
    logic signed [12:0] dclip_w;
    logic signed [12:0] tc_x_w;
    logic [12:0]        dabs_w;
    logic [8:0]         tc10_w;
    logic               on_w;
    logic [PIX_W-1:0]   p0f_w, q0f_w;

    assign p0_w = seg.pix_p[PIX_W-1:0];
    assign p1_w = seg.pix_p[2*PIX_W-1:PIX_W];
    assign q0_w = seg.pix_q[PIX_W-1:0];
    assign q1_w = seg.pix_q[2*PIX_W-1:PIX_W];

    always_comb begin
        // (9*(q0-p0) - 3*(q1-p1) + 8) >> 4
        delta_w = (13'sd9 * ($signed({5'b0, q0_w}) - $signed({5'b0, p0_w}))
                 - 13'sd3 * ($signed({5'b0, q1_w}) - $signed({5'b0, p1_w}))
                 + 13'sd8) >>> 4;
        dabs_w  = delta_w[12] ? 13'(-delta_w) : 13'(delta_w);
        tc10_w  = {4'b0, seg.tc} * 9'd10;
        tc_x_w  = $signed({8'b0, seg.tc});
        on_w    = (seg.bs != '0) && (dabs_w < {4'b0, tc10_w});

        if (delta_w > tc_x_w)
            dclip_w = tc_x_w;
        else if (delta_w < -tc_x_w)
            dclip_w = -tc_x_w;
        else
            dclip_w = delta_w;

        if (on_w) begin
            p0f_w = clip_pix($signed({2'b00, p0_w}) + $signed(dclip_w[9:0]));
            q0f_w = clip_pix($signed({2'b00, q0_w}) - $signed(dclip_w[9:0]));
        end else begin
            p0f_w = p0_w;                       // pass through
            q0f_w = q0_w;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pix.valid <= 1'b0;
        else
            pix.valid <= seg.valid;
    end

    always_ff @(posedge clk) begin
        if (seg.valid) begin
            pix.bs    <= seg.bs;
            pix.pix_p <= {seg.pix_p[PIX4_W-1:PIX_W], p0f_w};
            pix.pix_q <= {seg.pix_q[PIX4_W-1:PIX_W], q0f_w};
            pix.sao_p <= sao_p_i;
            pix.sao_q <= sao_q_i;
        end
    end

endmodule

// File: rtl/db_sao_offset.sv
// SAO on the eight filtered pixels p3..p0 q0..q3
// band offset on all four pixels of a side, edge offset (horizontal
// class) on the inner six, p side uses sao_p and q side sao_q
`timescale 1ns/1ps

module db_sao_offset (
    input  logic                        clk,
    input  logic                        rst_n,
    db_pix_if.dst                       pix,
    output logic                        out_valid_o,
    output logic [db_pkg::BS_W-1:0]     out_bs_o,
    output logic [db_pkg::PIX4_W-1:0]   out_p_o,
    output logic [db_pkg::PIX4_W-1:0]   out_q_o
);
    import db_pkg::*;

    logic [PIX_W-1:0] row_w [8];        // 0 = p3 ... 7 = q3
    logic [PIX_W-1:0] res_w [8];

    // one pixel through SAO, a and b are its row neighbours
    function automatic logic [PIX_W-1:0] sao_pix(
        input sao_word_u        w,
        input logic [PIX_W-1:0] c,
        input logic [PIX_W-1:0] a,
        input logic [PIX_W-1:0] b,
        input logic             eo_ok   // p3 / q3 lack a neighbour
    );
        logic [4:0]        k;
        logic [1:0]        lt, gt;
        logic signed [4:0] off;
        off = '0;
        if (w.bo.typ == SAO_BAND) begin
            k = c[PIX_W-1:3] - w.bo.band_pos;   // band index wraps mod 32
            if (k < 5'd4)
                off = 5'($signed(w.bo.off[k[1:0]]));
        end else if (w.eo.typ == SAO_EDGE && eo_ok) begin
            lt = 2'(c < a) + 2'(c < b);
            gt = 2'(c > a) + 2'(c > b);
            if (lt == 2'd2)
                off = $signed({1'b0, w.eo.mag[0]});     // local min
            else if (lt == 2'd1 && gt == 2'd0)
                off = $signed({1'b0, w.eo.mag[1]});
            else if (gt == 2'd1 && lt == 2'd0)
                off = -$signed({1'b0, w.eo.mag[2]});
            else if (gt == 2'd2)
                off = -$signed({1'b0, w.eo.mag[3]});    // local max
        end
        return clip_pix($signed({2'b00, c}) + off);
    endfunction

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            row_w[3-i] = pix.pix_p[PIX_W*i +: PIX_W];   // p_i
            row_w[4+i] = pix.pix_q[PIX_W*i +: PIX_W];   // q_i
        end
    end

    // ******************************************************************
    // per pixel offset
    // ******************************************************************
    for (genvar i = 0; i < 8; i++) begin : g_pix
        assign res_w[i] = sao_pix((i < 4) ? pix.sao_p : pix.sao_q,
                                  row_w[i],
                                  row_w[(i == 0) ? 0 : i-1],
                                  row_w[(i == 7) ? 7 : i+1],
                                  (i != 0) && (i != 7));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            out_valid_o <= 1'b0;
        else
            out_valid_o <= pix.valid;
    end

    always_ff @(posedge clk) begin
        if (pix.valid) begin
            out_bs_o <= pix.bs;
            for (int i = 0; i < 4; i++) begin
                out_p_o[PIX_W*i +: PIX_W] <= res_w[3-i];
                out_q_o[PIX_W*i +: PIX_W] <= res_w[4+i];
            end
        end
    end

endmodule

// File: rtl/db_top.sv
// top of the deblock + SAO slice, plain ports only
// stage 1: bs calc and SAO pick side by side, stage 2: luma filter,
// stage 3: SAO offset; out_valid_o follows seg_valid_i by 3 cycles
`timescale 1ns/1ps

module db_top (
    input  logic                         clk,
    input  logic                         rst_n,
    // lcu parameters
    input  logic                         lcu_start_i,
    input  logic [db_pkg::LCU_X_W-1:0]   lcu_x_i,
    input  logic [db_pkg::SAO_W-1:0]     lcu_sao_i,
    // segment
    input  logic                         seg_valid_i,
    input  logic                         seg_ver_i,
    input  logic                         seg_lcu_edge_i,
    input  logic                         intra_i,
    input  logic                         tu_edge_i,
    input  logic                         pu_edge_i,
    input  logic                         cbf_p_i,
    input  logic                         cbf_q_i,
    input  logic [2*db_pkg::MV_W-1:0]    mv_p_i,
    input  logic [2*db_pkg::MV_W-1:0]    mv_q_i,
    input  logic [db_pkg::QP_W-1:0]      qp_i,
    input  logic [db_pkg::PIX4_W-1:0]    pix_p_i,
    input  logic [db_pkg::PIX4_W-1:0]    pix_q_i,
    // result
    output logic                         out_valid_o,
    output logic [db_pkg::BS_W-1:0]      out_bs_o,
    output logic [db_pkg::PIX4_W-1:0]    out_p_o,
    output logic [db_pkg::PIX4_W-1:0]    out_q_o
);
    import db_pkg::*;

    sao_word_u sao_p_w;     // stage 1 picks, aligned with seg_if
    sao_word_u sao_q_w;

    db_seg_if seg_if ();
    db_pix_if pix_if ();

    db_bs_calc u_bs (
        .clk         (clk),
        .rst_n       (rst_n),
        .seg_valid_i (seg_valid_i),
        .intra_i     (intra_i),
        .tu_edge_i   (tu_edge_i),
        .pu_edge_i   (pu_edge_i),
        .cbf_p_i     (cbf_p_i),
        .cbf_q_i     (cbf_q_i),
        .mv_p_i      (mv_p_i),
        .mv_q_i      (mv_q_i),
        .qp_i        (qp_i),
        .pix_p_i     (pix_p_i),
        .pix_q_i     (pix_q_i),
        .seg         (seg_if.src)
    );

    db_sao_select u_sel (
        .clk            (clk),
        .rst_n          (rst_n),
        .lcu_start_i    (lcu_start_i),
        .lcu_x_i        (lcu_x_i),
        .lcu_sao_i      (lcu_sao_i),    // raw vector into the union port
        .seg_valid_i    (seg_valid_i),
        .seg_ver_i      (seg_ver_i),
        .seg_lcu_edge_i (seg_lcu_edge_i),
        .sao_p_o        (sao_p_w),
        .sao_q_o        (sao_q_w)
    );

    db_luma_filter u_flt (
        .clk     (clk),
        .rst_n   (rst_n),
        .seg     (seg_if.dst),
        .sao_p_i (sao_p_w),
        .sao_q_i (sao_q_w),
        .pix     (pix_if.src)
    );

    db_sao_offset u_sao (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix         (pix_if.dst),
        .out_valid_o (out_valid_o),
        .out_bs_o    (out_bs_o),
        .out_p_o     (out_p_o),
        .out_q_o     (out_q_o)
    );

endmodule

// File: bench/db_chk.sv
// concurrent checks on the result port of db_top
// bound onto db_top from the testbench, fires $error on a violation
// covers the 3-cycle latency, the bs range and X on valid data
`timescale 1ns/1ps

module db_chk (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         seg_valid_i,
    input logic                         out_valid_o,
    input logic [db_pkg::BS_W-1:0]      out_bs_o,
    input logic [db_pkg::PIX4_W-1:0]    out_p_o,
    input logic [db_pkg::PIX4_W-1:0]    out_q_o
);

    // segment in -> result out, three edges later
    a_lat_fwd: assert property (@(posedge clk) disable iff (!rst_n)
        seg_valid_i |-> ##3 out_valid_o)
        else $error("no result 3 cycles after seg_valid_i");

    // and nothing comes out that was not sent
    a_lat_back: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_o |-> $past(seg_valid_i, 3))
        else $error("out_valid_o without a segment 3 cycles before");

    a_bs_range: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_o |-> (out_bs_o != 2'd3))
        else $error("out_bs_o holds the unused code 3");

    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid_o))
        else $error("out_valid_o is unknown");

    a_data_known: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_o |-> !$isunknown({out_bs_o, out_p_o, out_q_o}))
        else $error("unknown bits on the result while out_valid_o is high");

endmodule

// File: bench/db_tb.sv
// testbench for db_top, the deblocking + SAO slice
// LFSR driven LCUs and segments, a reference model in plain ints,
// a queue of expected results popped on each out_valid_o
// checks are sampled on the falling edge, inputs move 1 ns after rise
`timescale 1ns/1ps

module db_tb;

    localparam int          CLK_PERIOD  = 4;
    localparam int          DRIVE_DLY   = 1;
    localparam logic [31:0] SEED        = 32'd80;
    localparam int          ROWS        = 4;     // lcu rows
    localparam int          COLS        = 6;     // lcu columns per row
    localparam int          DRAIN_LIMIT = 50;    // cycles to wait for the tail

    // tc for index 18..53
    localparam int TC_REF [36] = '{1, 1, 1, 1, 1, 1, 1, 1, 1, 2, 2, 2, 2, 3, 3, 3, 3,
                                   4, 4, 4, 5, 5, 6, 6, 7, 8, 9, 10, 11, 13, 14, 16,
                                   18, 20, 22, 24};
    localparam int MV_STEP [8] = '{0, 3, 4, -3, -4, 2, 5, -4};  // 3 vs 4 boundary

    logic        clk = 1'b0;            // low before time 0, no edge at start
    logic        rst_n;
    logic        lcu_start_i;
    logic [3:0]  lcu_x_i;
    logic [18:0] lcu_sao_i;
    logic        seg_valid_i, seg_ver_i, seg_lcu_edge_i;
    logic        intra_i, tu_edge_i, pu_edge_i, cbf_p_i, cbf_q_i;
    logic [19:0] mv_p_i, mv_q_i;
    logic [5:0]  qp_i;
    logic [31:0] pix_p_i, pix_q_i;
    logic        out_valid_o;
    logic [1:0]  out_bs_o;
    logic [31:0] out_p_o, out_q_o;

    logic [31:0] lfsr;
    logic [18:0] cur_m, left_m, top_m;  // model copy of the SAO store
    logic [18:0] top_store [16];
    logic [65:0] exp_q [$];             // {bs, p, q}
    logic [2:0]  vhist;                 // seg_valid_i over the last edges
    int          check_cnt, err_cnt, misc_cnt, seg_cnt;

    db_top uut (.*);

    bind db_top db_chk u_chk (.*);

    initial begin
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // ******************************************************************
    // random source and checking
    // ******************************************************************
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];                 // one step per bit
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic compare(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // ******************************************************************
    // reference model
    // ******************************************************************
    function automatic int clamp_pix(input int v);
        if (v < 0)
            return 0;
        if (v > 255)
            return 255;
        return v;
    endfunction

    function automatic int tc_value(input int qp, input int bs);
        int idx;
        idx = qp + ((bs == 2) ? 2 : 0);
        if (idx > 53)
            idx = 53;
        if (idx < 18)
            return 0;
        return TC_REF[idx-18];
    endfunction

    function automatic int bs_expected(input logic intra, tu, pu, cbf_p, cbf_q,
                                       input logic [19:0] mvp, mvq);
        int dx, dy;
        dx = $signed(mvp[9:0]) - $signed(mvq[9:0]);     // x in the low half
        dy = $signed(mvp[19:10]) - $signed(mvq[19:10]);
        if (dx < 0)
            dx = -dx;
        if (dy < 0)
            dy = -dy;
        if (intra && (tu || pu))
            return 2;
        if (tu && (cbf_p || cbf_q))
            return 1;
        if (pu && (dx >= 4 || dy >= 4))
            return 1;
        return 0;
    endfunction

    // new {p0, q0}
    function automatic logic [15:0] weak_filter(input int bs, tc, p0, p1, q0, q1);
        int d;
        d = (9 * (q0 - p0) - 3 * (q1 - p1) + 8) >>> 4;
        if (bs == 0 || ((d < 0) ? -d : d) >= 10 * tc)
            return {8'(p0), 8'(q0)};        // filter off
        if (d > tc)
            d = tc;
        else if (d < -tc)
            d = -tc;
        return {8'(clamp_pix(p0 + d)), 8'(clamp_pix(q0 - d))};
    endfunction

    // c with row neighbours a, b
    function automatic int sao_apply(input logic [18:0] w, input int c, a, b,
                                     input bit inner);
        int k, v, cat;
        cat = 0;
        if (w[18:17] == 2'd1) begin
            k = ((c >> 3) - w[16:12]) & 31;  // band distance mod 32
            if (k < 4) begin
                v = w[3*k +: 3];
                return clamp_pix(c + ((v >= 4) ? v - 8 : v));
            end
        end else if (w[18:17] == 2'd2 && inner) begin
            if (c < a && c < b)
                cat = 1;
            else if ((c < a && c == b) || (c == a && c < b))
                cat = 2;
            else if ((c > a && c == b) || (c == a && c > b))
                cat = 3;
            else if (c > a && c > b)
                cat = 4;
            if (cat != 0) begin
                v = w[4*cat-3 +: 4];        // magnitude of this category
                return clamp_pix((cat <= 2) ? c + v : c - v);
            end
        end
        return c;
    endfunction

    // ******************************************************************
    // stimulus
    // ******************************************************************
    task automatic idle_cycle();
        @(posedge clk);
        #DRIVE_DLY;
        lcu_start_i = 1'b0;
        seg_valid_i = 1'b0;
    endtask

    task automatic start_lcu(input int x);
        logic [31:0] r;
        logic [31:0] m;
        draw_bits(19, r);
        draw_bits(2, m);
        if (r[18:17] == 2'd1 && m[1:0] == 2'd0)
            r[16:12] = 5'd0;                // bands near black
        else if (r[18:17] == 2'd1 && m[1:0] == 2'd1)
            r[16:12] = 5'd29;               // bands near white
        @(posedge clk);
        #DRIVE_DLY;
        seg_valid_i = 1'b0;
        lcu_start_i = 1'b1;
        lcu_x_i     = 4'(x);
        lcu_sao_i   = r[18:0];
        left_m        = cur_m;
        cur_m         = r[18:0];
        top_m         = top_store[x];
        top_store[x]  = r[18:0];
    endtask

    task automatic send_segment();
        logic [31:0] f, m, r, pp, pq, ep, eq;
        logic [19:0] mvp, mvq;
        logic [18:0] sp;
        logic [15:0] fl;
        int          base, step, bs, tc;
        int          row [8];
        int          res [8];
        draw_bits(7, f);
        draw_bits(20, r);
        mvp = r[19:0];
        mvq = mvp;
        draw_bits(5, m);
        if (m[4]) begin
            draw_bits(20, r);
            mvq = r[19:0];
        end else if (m[3]) begin
            mvq[19:10] = mvp[19:10] + 10'(MV_STEP[m[2:0]]);
        end else begin
            mvq[9:0] = mvp[9:0] + 10'(MV_STEP[m[2:0]]);
        end
        draw_bits(2, m);
        if (m[1:0] == 2'd0) begin
            draw_bits(32, pp);              // noise, filter mostly skips
            draw_bits(32, pq);
        end else begin
            draw_bits(8, r);
            if (m[1:0] == 2'd1)
                base = r[2:0];
            else if (m[1:0] == 2'd2)
                base = 248 + r[2:0];
            else
                base = r[7:0];
            draw_bits(3, r);
            step = r[2:0];                  // small edge step
            for (int i = 0; i < 4; i++) begin
                draw_bits(2, r);
                pp[8*i +: 8] = 8'(clamp_pix(base + int'(r[1:0]) - 1));
                draw_bits(2, r);
                pq[8*i +: 8] = 8'(clamp_pix(base + step + int'(r[1:0]) - 1));
            end
        end
        draw_bits(6, r);

        bs = bs_expected(f[0], f[1], f[2], f[3], f[4], mvp, mvq);
        tc = tc_value(r[5:0], bs);
        for (int i = 0; i < 4; i++) begin
            row[3-i] = pp[8*i +: 8];        // row 0 = p3 ... 7 = q3
            row[4+i] = pq[8*i +: 8];
        end
        fl = weak_filter(bs, tc, row[3], row[2], row[4], row[5]);
        row[3] = fl[15:8];
        row[4] = fl[7:0];
        sp = !f[6] ? cur_m : (f[5] ? left_m : top_m);
        for (int i = 0; i < 8; i++) begin
            res[i] = sao_apply((i < 4) ? sp : cur_m, row[i], row[(i == 0) ? 0 : i-1],
                               row[(i == 7) ? 7 : i+1], (i != 0) && (i != 7));
        end
        for (int i = 0; i < 4; i++) begin
            ep[8*i +: 8] = 8'(res[3-i]);
            eq[8*i +: 8] = 8'(res[4+i]);
        end
        exp_q.push_back({2'(bs), ep, eq});
        seg_cnt++;

        @(posedge clk);
        #DRIVE_DLY;
        lcu_start_i    = 1'b0;
        seg_valid_i    = 1'b1;
        intra_i        = f[0];
        tu_edge_i      = f[1];
        pu_edge_i      = f[2];
        cbf_p_i        = f[3];
        cbf_q_i        = f[4];
        seg_ver_i      = f[5];
        seg_lcu_edge_i = f[6];
        mv_p_i         = mvp;
        mv_q_i         = mvq;
        qp_i           = r[5:0];
        pix_p_i        = pp;
        pix_q_i        = pq;
    endtask

    // ******************************************************************
    // result monitor, falling edge so outputs have settled
    // ******************************************************************
    always @(negedge clk) begin : monitor
        logic [65:0] e;
        compare("out_valid_o vs seg_valid_i 3 cycles back",
                32'(out_valid_o), 32'(vhist[2]));
        vhist = {vhist[1:0], seg_valid_i};
        if (out_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                misc_cnt++;
                $display("result at %0t ns while no segment was outstanding", $time);
            end else begin
                e = exp_q.pop_front();
                compare("out_bs_o", 32'(out_bs_o), 32'(e[65:64]));
                compare("out_p_o", out_p_o, e[63:32]);
                compare("out_q_o", out_q_o, e[31:0]);
            end
        end
    end

    initial begin : main
        logic [31:0] r;
        int          nseg, waited;
        lfsr      = SEED;
        check_cnt = 0;
        err_cnt   = 0;
        misc_cnt  = 0;
        seg_cnt   = 0;
        vhist     = '0;
        cur_m     = '0;
        left_m    = '0;
        top_m     = '0;
        for (int i = 0; i < 16; i++) begin
            top_store[i] = '0;              // no row above the first
        end
        rst_n          = 1'b0;
        lcu_start_i    = 1'b0;
        lcu_x_i        = '0;
        lcu_sao_i      = '0;
        seg_valid_i    = 1'b0;
        seg_ver_i      = 1'b0;
        seg_lcu_edge_i = 1'b0;
        intra_i        = 1'b0;
        tu_edge_i      = 1'b0;
        pu_edge_i      = 1'b0;
        cbf_p_i        = 1'b0;
        cbf_q_i        = 1'b0;
        mv_p_i         = '0;
        mv_q_i         = '0;
        qp_i           = '0;
        pix_p_i        = '0;
        pix_q_i        = '0;

        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        repeat (2) idle_cycle();

        for (int row = 0; row < ROWS; row++) begin
            for (int col = 0; col < COLS; col++) begin
                start_lcu(col);
                draw_bits(3, r);
                nseg = 6 + r[2:0];
                for (int s = 0; s < nseg; s++) begin
                    send_segment();
                    draw_bits(2, r);
                    if (!r[1])
                        repeat (r[0] + 1) idle_cycle();    // else back-to-back
                end
            end
        end
        idle_cycle();

        // let the pipeline empty
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            misc_cnt++;
            $display("timeout: %0d results never came out", exp_q.size());
        end
        repeat (4) idle_cycle();

        $display("summary: %0d segments, %0d checks, %0d value errors, %0d other errors",
                 seg_cnt, check_cnt, err_cnt, misc_cnt);
        if (err_cnt == 0 && misc_cnt == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: sim.f
rtl/db_pkg.sv
rtl/db_if.sv
rtl/db_bs_calc.sv
rtl/db_sao_select.sv
rtl/db_luma_filter.sv
rtl/db_sao_offset.sv
rtl/db_top.sv
bench/db_chk.sv
bench/db_tb.sv

// File: Bender.yml
package:
  name: db_slice

sources:
  - files:
      - rtl/db_pkg.sv
      - rtl/db_if.sv
      - rtl/db_bs_calc.sv
      - rtl/db_sao_select.sv
      - rtl/db_luma_filter.sv
      - rtl/db_sao_offset.sv
      - rtl/db_top.sv
  - target: simulation
    files:
      - bench/db_chk.sv
      - bench/db_tb.sv
